//--- hdl/nts_engine_defs.svh
/*
 * Bus widths, register offsets and identity constants of the NTS engine.
 * Included by the package, the RTL and the testbench.
 */

`ifndef NTS_ENGINE_DEFS_SVH
`define NTS_ENGINE_DEFS_SVH

// API bus geometry
`define NTS_API_ADDR_W   12
`define NTS_API_DATA_W   32
`define NTS_API_OFFSET_W 8 // Low byte, upper nibble selects the block

// Engine register offsets
`define NTS_REG_NAME0   8'h00
`define NTS_REG_NAME1   8'h01
`define NTS_REG_VERSION 8'h02
`define NTS_REG_CTRL    8'h08
`define NTS_REG_STATUS  8'h09

// Identity words, ASCII
`define NTS_CORE_NAME0   32'h4e54_535f // NTS_
`define NTS_CORE_NAME1   32'h454e_474e // ENGN
`define NTS_CORE_VERSION 32'h302e_3035 // 0.05

// Debug offsets, each counter takes two words
`define NTS_DBG_PROCESSED  8'h00
`define NTS_DBG_BAD_COOKIE 8'h02
`define NTS_DBG_BAD_AUTH   8'h04
`define NTS_DBG_BAD_KEYID  8'h06
`define NTS_DBG_NAME       8'h08
`define NTS_DBG_SYSTICK    8'h09
`define NTS_DBG_ERR_CRYPTO 8'h20
`define NTS_DBG_ERR_TXBUF  8'h22

`define NTS_DEBUG_NAME 32'h4442_5547 // DBUG
`define NTS_COUNTER_W  64

`endif

//--- hdl/nts_engine_pkg.sv
/*
 * Shared types of the NTS engine register block.
 * Imported by every RTL file and the testbench.
 */

`default_nettype none

`include "nts_engine_defs.svh"

package nts_engine_pkg;

  // Upper nibble of the API address
  typedef enum logic [3:0] {
    BLK_ENGINE = 4'd0,
    BLK_DEBUG  = 4'd4
  } api_block_e;

  // Statistics counter index, also the event vector bit
  typedef enum logic [2:0] {
    CNT_PROCESSED,
    CNT_BAD_COOKIE,
    CNT_BAD_AUTH,
    CNT_BAD_KEYID,
    CNT_ERR_CRYPTO,
    CNT_ERR_TXBUF
  } counter_e;

  localparam int NTS_NUM_COUNTERS = 6;

  typedef logic [`NTS_API_DATA_W-1:0] api_word_t;
  typedef logic [`NTS_COUNTER_W-1:0]  counter_t;

endpackage

`default_nettype wire

//--- hdl/nts_api_if.sv
/*
 * Internal API bus from the address decoder to the register blocks.
 * Selects are single-cycle, read data returns combinationally.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

interface nts_api_if
  import nts_engine_pkg::*;
();

  logic                         we;
  logic [`NTS_API_OFFSET_W-1:0] offset;
  api_word_t                    wdata;
  logic                         sel_engine;
  logic                         sel_debug;
  api_word_t                    rdata_engine; // Zero when not selected
  api_word_t                    rdata_debug;

  modport decoder (output we, offset, wdata, sel_engine, sel_debug,
                   input  rdata_engine, rdata_debug);

  modport engine  (input  we, offset, wdata, sel_engine,
                   output rdata_engine);

  modport debug   (input  we, offset, sel_debug,
                   output rdata_debug);

endinterface

`default_nettype wire

//--- hdl/nts_api_decode.sv
/*
 * API address decoder. Splits the address into block and offset, raises
 * the block select and returns read data one cycle after the request.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module nts_api_decode
  import nts_engine_pkg::*;
(
  input  wire                        i_clk,
  input  wire                        i_areset,
  input  wire                        i_api_cs,
  input  wire                        i_api_we,
  input  wire [`NTS_API_ADDR_W-1:0]  i_api_address,
  input  api_word_t                  i_api_write_data,
  output api_word_t                  o_api_read_data,
  output logic                       o_api_read_data_valid,
  nts_api_if.decoder                 api
);

  api_block_e block;
  api_word_t  read_mux;
  logic       api_read;

  assign block    = api_block_e'(i_api_address[`NTS_API_ADDR_W-1:`NTS_API_OFFSET_W]);
  assign api_read = i_api_cs && !i_api_we;

  // Request towards the blocks
  assign api.we         = i_api_we;
  assign api.offset     = i_api_address[`NTS_API_OFFSET_W-1:0];
  assign api.wdata      = i_api_write_data;
  assign api.sel_engine = i_api_cs && (block == BLK_ENGINE);
  assign api.sel_debug  = i_api_cs && (block == BLK_DEBUG);

  always_comb
  begin
    case (block)
      BLK_ENGINE: read_mux = api.rdata_engine;
      BLK_DEBUG:  read_mux = api.rdata_debug;
      default:    read_mux = '0; // Removed blocks read as zero
    endcase
  end

  // ------------------------------
  // Return path, one cycle latency
  // ------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_api_read_data_valid <= 1'b0;
      o_api_read_data       <= '0;
    end
    else
    begin
      o_api_read_data_valid <= api_read;
      if (api_read)
        o_api_read_data <= read_mux; // Hold last read otherwise
    end
  end

endmodule

`default_nettype wire

//--- hdl/nts_engine_regs.sv
/*
 * Engine register block: identity words, control and status.
 * Bit 0 of the control register enables the engine.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module nts_engine_regs
  import nts_engine_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_areset,
  input  wire        i_parser_busy,
  output logic       o_enable,
  nts_api_if.engine  api
);

  logic ctrl_reg;
  logic ctrl_we;

  assign ctrl_we  = api.sel_engine && api.we && (api.offset == `NTS_REG_CTRL);
  assign o_enable = ctrl_reg;

  // ------------------------------
  // Control register
  // ------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      ctrl_reg <= 1'b0; // Engine starts disabled
    else if (ctrl_we)
      ctrl_reg <= api.wdata[0];
  end

  // ------------------------------
  // Read data
  // ------------------------------
  always_comb
  begin
    api.rdata_engine = '0;
    if (api.sel_engine && !api.we)
    begin
      case (api.offset)
        `NTS_REG_NAME0:   api.rdata_engine = `NTS_CORE_NAME0;
        `NTS_REG_NAME1:   api.rdata_engine = `NTS_CORE_NAME1;
        `NTS_REG_VERSION: api.rdata_engine = `NTS_CORE_VERSION;
        `NTS_REG_CTRL:    api.rdata_engine[0] = ctrl_reg;
        // Ready when the parser is idle
        `NTS_REG_STATUS:  api.rdata_engine[0] = ~i_parser_busy;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/nts_debug_counters.sv
/*
 * Debug block: 64-bit statistics counters and a free-running systick.
 * Reading a counter's upper word snapshots its lower word for the next read.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module nts_debug_counters
  import nts_engine_pkg::*;
(
  input  wire                        i_clk,
  input  wire                        i_areset,
  input  wire [NTS_NUM_COUNTERS-1:0] i_events,
  nts_api_if.debug                   api
);

  // Upper word offset of each counter, indexed by counter_e
  localparam logic [`NTS_API_OFFSET_W-1:0] CNT_BASE [NTS_NUM_COUNTERS] = '{
    `NTS_DBG_PROCESSED,
    `NTS_DBG_BAD_COOKIE,
    `NTS_DBG_BAD_AUTH,
    `NTS_DBG_BAD_KEYID,
    `NTS_DBG_ERR_CRYPTO,
    `NTS_DBG_ERR_TXBUF
  };

  counter_t                    counter [NTS_NUM_COUNTERS];
  logic [31:0]                 lsb_snap [NTS_NUM_COUNTERS];
  logic [NTS_NUM_COUNTERS-1:0] snap_we;
  logic [31:0]                 systick;

  // ------------------------------
  // Counters and snapshots
  // ------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < NTS_NUM_COUNTERS; i++)
      begin
        counter[i]  <= '0;
        lsb_snap[i] <= '0;
      end
      systick <= 32'd1;
    end
    else
    begin
      for (int i = 0; i < NTS_NUM_COUNTERS; i++)
      begin
        if (i_events[i])
          counter[i] <= counter[i] + 1'b1;
        if (snap_we[i])
          lsb_snap[i] <= counter[i][31:0]; // Value before this cycle's event
      end
      systick <= systick + 1'b1;
    end
  end

  // ------------------------------
  // Read decode
  // ------------------------------
  always_comb
  begin
    api.rdata_debug = '0;
    snap_we         = '0;
    if (api.sel_debug && !api.we) // Writes have no effect here
    begin
      case (api.offset)
        `NTS_DBG_NAME:    api.rdata_debug = `NTS_DEBUG_NAME;
        `NTS_DBG_SYSTICK: api.rdata_debug = systick;
        default: ;
      endcase
      for (int i = 0; i < NTS_NUM_COUNTERS; i++)
      begin
        if (api.offset == CNT_BASE[i])
        begin
          api.rdata_debug = counter[i][63:32];
          snap_we[i]      = 1'b1;
        end
        else if (api.offset == CNT_BASE[i] + 8'd1)
          api.rdata_debug = lsb_snap[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/nts_engine_top.sv
/*
 * NTS engine register block top level. Connects the API decoder, the
 * engine registers and the debug counters, and forms the busy output.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module nts_engine_top
  import nts_engine_pkg::*;
(
  input  wire                       i_clk,
  input  wire                       i_areset,
  input  wire                       i_api_cs,
  input  wire                       i_api_we,
  input  wire [`NTS_API_ADDR_W-1:0] i_api_address,
  input  api_word_t                 i_api_write_data,
  input  wire                       i_parser_busy,
  input  wire                       i_stat_processed,
  input  wire                       i_stat_bad_cookie,
  input  wire                       i_stat_bad_auth,
  input  wire                       i_stat_bad_keyid,
  input  wire                       i_err_crypto,
  input  wire                       i_err_txbuf,
  output api_word_t                 o_api_read_data,
  output logic                      o_api_read_data_valid,
  output logic                      o_busy
);

  logic [NTS_NUM_COUNTERS-1:0] events;
  logic                        enable;

  nts_api_if u_api ();

  // Statistics pulses by counter index
  assign events[CNT_PROCESSED]  = i_stat_processed;
  assign events[CNT_BAD_COOKIE] = i_stat_bad_cookie;
  assign events[CNT_BAD_AUTH]   = i_stat_bad_auth;
  assign events[CNT_BAD_KEYID]  = i_stat_bad_keyid;
  assign events[CNT_ERR_CRYPTO] = i_err_crypto;
  assign events[CNT_ERR_TXBUF]  = i_err_txbuf;

  assign o_busy = ~enable | i_parser_busy; // Busy while disabled

  nts_api_decode u_decode (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_api_cs              (i_api_cs),
    .i_api_we              (i_api_we),
    .i_api_address         (i_api_address),
    .i_api_write_data      (i_api_write_data),
    .o_api_read_data       (o_api_read_data),
    .o_api_read_data_valid (o_api_read_data_valid),
    .api                   (u_api.decoder)
  );

  nts_engine_regs u_regs (
    .i_clk         (i_clk),
    .i_areset      (i_areset),
    .i_parser_busy (i_parser_busy),
    .o_enable      (enable),
    .api           (u_api.engine)
  );

  nts_debug_counters u_debug (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_events (events),
    .api      (u_api.debug)
  );

endmodule

`default_nettype wire

//--- testbench/nts_engine_asserts.sv
/*
 * Concurrent checks on the API read strobe and the busy output,
 * bound into the engine top level.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module nts_engine_asserts
  import nts_engine_pkg::*;
(
  input wire                       i_clk,
  input wire                       i_areset,
  input wire                       i_api_cs,
  input wire                       i_api_we,
  input wire [`NTS_API_ADDR_W-1:0] i_api_address,
  input wire [`NTS_API_DATA_W-1:0] i_api_write_data,
  input wire                       i_read_data_valid,
  input wire                       i_busy
);

  int   error_count = 0; // Failures seen so far
  logic ctrl_model;      // Control bit as last written over the API

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      ctrl_model <= 1'b0;
    else if (i_api_cs && i_api_we && (i_api_address == {BLK_ENGINE, `NTS_REG_CTRL}))
      ctrl_model <= i_api_write_data[0];
  end

  // Valid exactly one cycle after a read request
  read_valid_follows: assert property (@(posedge i_clk) disable iff (i_areset)
    (i_api_cs && !i_api_we) |=> i_read_data_valid)
  else
  begin
    $error("read request without valid strobe in the next cycle");
    error_count++;
  end

  no_valid_without_read: assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_api_cs && !i_api_we) |=> !i_read_data_valid)
  else
  begin
    $error("valid strobe after a cycle without read request");
    error_count++;
  end

  // Engine disabled means busy
  busy_while_disabled: assert property (@(posedge i_clk) disable iff (i_areset)
    !ctrl_model |-> i_busy)
  else
  begin
    $error("busy low while control enable bit is 0");
    error_count++;
  end

endmodule

bind nts_engine_top nts_engine_asserts u_asserts (
  .i_clk             (i_clk),
  .i_areset          (i_areset),
  .i_api_cs          (i_api_cs),
  .i_api_we          (i_api_we),
  .i_api_address     (i_api_address),
  .i_api_write_data  (i_api_write_data),
  .i_read_data_valid (o_api_read_data_valid),
  .i_busy            (o_busy)
);

`default_nettype wire

//--- testbench/tb_nts_engine.sv
/*
 * Directed testbench for the NTS engine register block. Drives the API bus
 * and the statistics inputs, and checks read data against the register map.
 */

`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_defs.svh"

module tb_nts_engine
  import nts_engine_pkg::*;
();

  localparam int CLK_PERIOD   = 100;
  localparam int READ_TIMEOUT = 10; // Cycles to wait for a valid strobe

  logic                        clk;
  logic                        areset;
  logic                        api_cs;
  logic                        api_we;
  logic [`NTS_API_ADDR_W-1:0]  api_address;
  api_word_t                   api_write_data;
  logic                        parser_busy;
  logic [NTS_NUM_COUNTERS-1:0] events;
  api_word_t                   read_data;
  logic                        read_data_valid;
  logic                        busy;

  counter_t expected_count [NTS_NUM_COUNTERS]; // Events applied so far
  int       error_count;
  int       failed_tests;
  int       errors_at_test_start;

  nts_engine_top u_dut (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_api_cs              (api_cs),
    .i_api_we              (api_we),
    .i_api_address         (api_address),
    .i_api_write_data      (api_write_data),
    .i_parser_busy         (parser_busy),
    .i_stat_processed      (events[CNT_PROCESSED]),
    .i_stat_bad_cookie     (events[CNT_BAD_COOKIE]),
    .i_stat_bad_auth       (events[CNT_BAD_AUTH]),
    .i_stat_bad_keyid      (events[CNT_BAD_KEYID]),
    .i_err_crypto          (events[CNT_ERR_CRYPTO]),
    .i_err_txbuf           (events[CNT_ERR_TXBUF]),
    .o_api_read_data       (read_data),
    .o_api_read_data_valid (read_data_valid),
    .o_busy                (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------
  // Address map and bus tasks
  // ------------------------------
  function automatic logic [`NTS_API_ADDR_W-1:0] api_addr(input logic [3:0] blk,
                                                          input logic [7:0] offset);
    return {blk, offset};
  endfunction

  // Upper word offset of each counter in the debug block
  function automatic logic [7:0] counter_offset(input counter_e c);
    case (c)
      CNT_PROCESSED:  return `NTS_DBG_PROCESSED;
      CNT_BAD_COOKIE: return `NTS_DBG_BAD_COOKIE;
      CNT_BAD_AUTH:   return `NTS_DBG_BAD_AUTH;
      CNT_BAD_KEYID:  return `NTS_DBG_BAD_KEYID;
      CNT_ERR_CRYPTO: return `NTS_DBG_ERR_CRYPTO;
      default:        return `NTS_DBG_ERR_TXBUF;
    endcase
  endfunction

  task automatic api_write(input logic [`NTS_API_ADDR_W-1:0] addr, input api_word_t data);
    @(posedge clk);
    api_cs         <= 1'b1;
    api_we         <= 1'b1;
    api_address    <= addr;
    api_write_data <= data;
    @(posedge clk);
    api_cs <= 1'b0;
    api_we <= 1'b0;
  endtask

  task automatic api_read(input logic [`NTS_API_ADDR_W-1:0] addr, output api_word_t data,
                          output time sampled_at);
    int waited;
    @(posedge clk);
    api_cs      <= 1'b1;
    api_we      <= 1'b0;
    api_address <= addr;
    @(posedge clk);
    sampled_at = $time; // Edge that takes the request
    api_cs <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!read_data_valid && waited < READ_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (read_data_valid)
      data = read_data;
    else
    begin
      $display("Read of address %h got no valid strobe within %0d cycles", addr,
               READ_TIMEOUT);
      error_count++;
      data = '0;
    end
  endtask

  task automatic pulse_event(input counter_e c, input int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge clk);
      events[c] <= 1'b1;
      @(posedge clk);
      events[c] <= 1'b0;
    end
  endtask

  // ------------------------------
  // Compare and report
  // ------------------------------
  task automatic check_word(input api_word_t got, input api_word_t exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (error_count == errors_at_test_start)
      $display("test %s passed", name);
    else
    begin
      $display("test %s failed with %0d errors", name, error_count - errors_at_test_start);
      failed_tests++;
    end
    errors_at_test_start = error_count;
  endtask

  // Reads both words of a counter and compares with the events applied
  task automatic check_count(input counter_e c);
    api_word_t upper;
    api_word_t lower;
    time       t;
    api_read(api_addr(BLK_DEBUG, counter_offset(c)), upper, t);
    api_read(api_addr(BLK_DEBUG, counter_offset(c) + 8'd1), lower, t);
    check_word(upper, expected_count[c][63:32], {c.name(), " upper word"});
    check_word(lower, expected_count[c][31:0], {c.name(), " lower word"});
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_identity();
    api_word_t data;
    time       t;
    api_read(api_addr(BLK_ENGINE, `NTS_REG_NAME0), data, t);
    check_word(data, `NTS_CORE_NAME0, "NAME0");
    api_read(api_addr(BLK_ENGINE, `NTS_REG_NAME1), data, t);
    check_word(data, `NTS_CORE_NAME1, "NAME1");
    api_read(api_addr(BLK_ENGINE, `NTS_REG_VERSION), data, t);
    check_word(data, `NTS_CORE_VERSION, "VERSION");
    api_read(api_addr(BLK_DEBUG, `NTS_DBG_NAME), data, t);
    check_word(data, `NTS_DEBUG_NAME, "debug name");
    api_read(api_addr(4'h3, 8'h00), data, t); // Removed block
    check_word(data, 32'h0, "unknown block");
    finish_test("identity");
  endtask

  task automatic test_control_busy();
    api_word_t data;
    time       t;
    api_read(api_addr(BLK_ENGINE, `NTS_REG_CTRL), data, t);
    check_word(data, 32'h0, "CTRL after reset");
    @(negedge clk);
    check_bit(busy, 1'b1, "o_busy while disabled");
    api_write(api_addr(BLK_ENGINE, `NTS_REG_CTRL), 32'h1);
    api_read(api_addr(BLK_ENGINE, `NTS_REG_CTRL), data, t);
    check_word(data, 32'h1, "CTRL after enable");
    for (int b = 1; b >= 0; b--)
    begin
      @(posedge clk);
      parser_busy <= b[0];
      @(negedge clk);
      check_bit(busy, b[0], "o_busy follows parser busy");
      api_read(api_addr(BLK_ENGINE, `NTS_REG_STATUS), data, t);
      check_word(data, {31'h0, ~b[0]}, "STATUS ready bit");
    end
    finish_test("control_busy");
  endtask

  task automatic test_counters();
    counter_e c;
    int       n;
    for (int i = 0; i < NTS_NUM_COUNTERS; i++)
    begin
      c = counter_e'(i);
      n = $urandom % 21;
      pulse_event(c, n);
      expected_count[c] += n;
      check_count(c);
    end
    finish_test("counters");
  endtask

  task automatic test_snapshot();
    api_word_t upper;
    api_word_t lower;
    counter_t  at_read;
    time       t;
    pulse_event(CNT_BAD_KEYID, 2); // Make sure the count is not zero
    expected_count[CNT_BAD_KEYID] += 2;
    at_read = expected_count[CNT_BAD_KEYID];
    api_read(api_addr(BLK_DEBUG, counter_offset(CNT_BAD_KEYID)), upper, t);
    pulse_event(CNT_BAD_KEYID, 3);
    expected_count[CNT_BAD_KEYID] += 3;
    api_read(api_addr(BLK_DEBUG, counter_offset(CNT_BAD_KEYID) + 8'd1), lower, t);
    check_word(upper, at_read[63:32], "upper word at snapshot");
    check_word(lower, at_read[31:0], "lower word holds snapshot");
    check_count(CNT_BAD_KEYID);
    finish_test("snapshot");
  endtask

  task automatic test_systick();
    api_word_t first;
    api_word_t second;
    time       t1;
    time       t2;
    int        gap;
    api_read(api_addr(BLK_DEBUG, `NTS_DBG_SYSTICK), first, t1);
    gap = 1 + $urandom % 20;
    repeat (gap) @(posedge clk);
    api_read(api_addr(BLK_DEBUG, `NTS_DBG_SYSTICK), second, t2);
    // Cycles between the two sampling edges
    check_word(second - first, api_word_t'((t2 - t1) / CLK_PERIOD), "systick advance");
    finish_test("systick");
  endtask

  task automatic test_ignored_writes();
    api_word_t data;
    time       t;
    api_write(api_addr(BLK_ENGINE, `NTS_REG_NAME0), $urandom);
    api_read(api_addr(BLK_ENGINE, `NTS_REG_NAME0), data, t);
    check_word(data, `NTS_CORE_NAME0, "NAME0 after write");
    api_write(api_addr(BLK_DEBUG, counter_offset(CNT_BAD_AUTH)), $urandom);
    api_write(api_addr(BLK_DEBUG, counter_offset(CNT_BAD_AUTH) + 8'd1), $urandom);
    check_count(CNT_BAD_AUTH);
    finish_test("ignored_writes");
  endtask

  initial
  begin
    void'($urandom(9));
    clk            = 1'b0;
    areset         = 1'b1;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = '0;
    api_write_data = '0;
    parser_busy    = 1'b0;
    events         = '0;
    error_count          = 0;
    failed_tests         = 0;
    errors_at_test_start = 0;
    foreach (expected_count[i])
      expected_count[i] = '0;

    repeat (4) @(posedge clk);
    areset <= 1'b0;

    test_identity();
    test_control_busy();
    test_counters();
    test_snapshot();
    test_systick();
    test_ignored_writes();

    $display("6 tests, %0d failed, %0d check errors, %0d assertion errors", failed_tests,
             error_count, u_dut.u_asserts.error_count);
    if (error_count == 0 && u_dut.u_asserts.error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/nts_engine_pkg.sv
hdl/nts_api_if.sv
hdl/nts_api_decode.sv
hdl/nts_engine_regs.sv
hdl/nts_debug_counters.sv
hdl/nts_engine_top.sv
testbench/nts_engine_asserts.sv
testbench/tb_nts_engine.sv

//--- Bender.yml
package:
  name: nts_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/nts_engine_pkg.sv
      - hdl/nts_api_if.sv
      - hdl/nts_api_decode.sv
      - hdl/nts_engine_regs.sv
      - hdl/nts_debug_counters.sv
      - hdl/nts_engine_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/nts_engine_asserts.sv
      - testbench/tb_nts_engine.sv
